/* files.f */
+incdir+tests
hdl/biu_pkg.sv
hdl/biu_arbiter.sv
hdl/biu_controller_wb.sv
hdl/wb_sram.sv
hdl/biu_top.sv
tests/biu_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ns -Wno-fatal \
    --top-module biu_tb -f files.f -o Vbiu_tb

status=0
out=$(./obj_dir/Vbiu_tb 2>&1) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "^Result: PASSED$"; then
    exit 0
fi
echo "Simulation did not pass (exit status $status)"
exit 1

/* tests/biu_tb_model.svh */
//****************************************
// Testbench model: LCG, shadow memory
// and reference read data
//****************************************
`ifndef BIU_TB_MODEL_SVH
`define BIU_TB_MODEL_SVH

// All test addresses stay inside this preloaded window
localparam int TEST_BYTES = 512;

logic [31:0] lcg_state = 32'hc71f_0a81;
logic [7:0]  shadow [TEST_BYTES];

// Halves swapped so the weak low state bits land on top
function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};
endfunction

// Byte pattern built from every address bit
function automatic logic [7:0] fill_byte(input logic [WB_ADDR_WIDTH-1:0] addr);
    return addr[7:0] ^ {addr[11:8], addr[11:8]} ^ 8'ha5;
endfunction

// Length in bytes over four, never below one beat
function automatic int beat_count(input biu_len_t len);
    int bytes;
    case (len)
        LEN_1B:  bytes = 1;
        LEN_2B:  bytes = 2;
        LEN_4B:  bytes = 4;
        LEN_8B:  bytes = 8;
        default: bytes = 16;
    endcase
    return (bytes < 4) ? 1 : bytes / 4;
endfunction

// Selected bytes of every beat land in the shadow copy
function automatic void apply_write(input biu_req_t req);
    for (int i = 0; i < beat_count(req.len) * 4; i++) begin
        if (req.sel[i]) begin
            shadow[int'(req.addr) + i] = req.data[i*8 +: 8];
        end
    end
endfunction

function automatic logic [BIU_DATA_WIDTH-1:0] expected_read(
    input logic [WB_ADDR_WIDTH-1:0] addr,
    input biu_len_t                 len
);
    logic [BIU_DATA_WIDTH-1:0] result;
    result = '0;
    for (int i = 0; i < beat_count(len) * 4; i++) begin
        result[i*8 +: 8] = shadow[int'(addr) + i];
    end
    return result;
endfunction

`endif

/* tests/biu_tb.sv */
//****************************************
// BIU testbench: clock, reset, requests,
// response checks and timeout
//****************************************
`timescale 1ns/1ns

module biu_tb;

    import biu_pkg::*;

    `include "biu_tb_model.svh"

    localparam int INIT_OPS  = TEST_BYTES / BIU_DATA_SIZE;
    localparam int PATCH_OPS = 12;
    localparam int MERGE_OPS = 12;
    localparam int SHORT_OPS = 8;
    localparam int PAIR_OPS  = 6;
    localparam int MIX_OPS   = 200;
    localparam int TOTAL_OPS = INIT_OPS + 10 + MIX_OPS
                             + 2 * (PATCH_OPS + MERGE_OPS + SHORT_OPS + PAIR_OPS);
    // 16-byte RMW plus a wait behind the other requester
    localparam int CYCLE_LIMIT = TOTAL_OPS * 90;

    typedef struct packed {
        biu_src_t src;
        logic     is_read;
        biu_rsp_t rsp;
    } pending_t;

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    biu_req_t fetch_req;
    biu_req_t lsu_req;
    biu_rsp_t fetch_rsp;
    biu_rsp_t lsu_rsp;
    pending_t pending_q[$];
    int       cycle_count = 0;
    int       done_count = 0;

    biu_top DUT (
        .i_wb_clk    (clk),
        .i_rst       (rst),
        .i_fetch_req (fetch_req),
        .i_lsu_req   (lsu_req),
        .o_fetch_rsp (fetch_rsp),
        .o_lsu_rsp   (lsu_rsp)
    );

    always #5 clk = ~clk;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input biu_rsp_t want, input biu_rsp_t got, input string name);
        if (want.data !== got.data) begin
            report_failure($sformatf("[ERROR] %0t ns %s: expected %h, got %h",
                                     $time, name, want.data, got.data));
        end
    endtask

    task automatic check_src(input biu_src_t want, input biu_src_t got);
        if (want !== got) begin
            report_failure($sformatf("[ERROR] %0t ns done source: expected %s, got %s",
                                     $time, want.name(), got.name()));
        end
    endtask

    function automatic biu_func_t random_func();
        logic [31:0] r;
        r = next_random();
        return biu_func_t'(2'(r % 3));
    endfunction

    function automatic biu_req_t random_req(input biu_func_t func);
        biu_req_t    req;
        logic [31:0] r;
        r        = next_random();
        req.en   = 1'b1;
        req.func = func;
        req.len  = biu_len_t'(3'(r % 5));
        req.addr = WB_ADDR_WIDTH'(4 * ((r >> 8) % ((TEST_BYTES - BIU_DATA_SIZE) / 4 + 1)));
        r        = next_random();
        req.sel  = r[BIU_DATA_SIZE-1:0];
        req.data = {next_random(), next_random(), next_random(), next_random()};
        return req;
    endfunction

    // Expected response in grant order, shadow updated for writes
    function automatic void record_expected(input biu_src_t src, input biu_req_t req);
        pending_t item;
        item.src      = src;
        item.is_read  = (req.func == READ);
        item.rsp.done = 1'b1;
        item.rsp.data = expected_read(req.addr, req.len);
        if (req.func != READ) begin
            apply_write(req);
        end
        pending_q.push_back(item);
    endfunction

    // Hold the request until its own done shows up
    task automatic issue(input biu_src_t src, input biu_req_t req);
        @(posedge clk);
        #1;
        if (src == SRC_FETCH) begin
            fetch_req = req;
        end else begin
            lsu_req = req;
        end
        do begin
            @(posedge clk);
            #1;
        end while (!((src == SRC_FETCH) ? fetch_rsp.done : lsu_rsp.done));
        if (src == SRC_FETCH) begin
            fetch_req.en = 1'b0;
        end else begin
            lsu_req.en = 1'b0;
        end
    endtask

    task automatic run_op(input biu_src_t src, input biu_req_t req);
        record_expected(src, req);
        issue(src, req);
    endtask

    // Same-cycle requests, fetch is served first
    task automatic run_pair(input biu_req_t f_req, input biu_req_t l_req);
        record_expected(SRC_FETCH, f_req);
        record_expected(SRC_LSU, l_req);
        fork
            issue(SRC_FETCH, f_req);
            issue(SRC_LSU, l_req);
        join
    endtask

    // Compare every done pulse with the oldest expected response
    always @(negedge clk) begin
        pending_t want;
        biu_src_t src;
        biu_rsp_t got;
        string    name;
        if (!rst && (fetch_rsp.done || lsu_rsp.done)) begin
            if (fetch_rsp.done && lsu_rsp.done) begin
                report_failure("Both requesters saw done in the same cycle");
            end else if (pending_q.size() == 0) begin
                report_failure("A done pulse arrived with no request outstanding");
            end else begin
                want = pending_q.pop_front();
                src  = fetch_rsp.done ? SRC_FETCH : SRC_LSU;
                got  = fetch_rsp.done ? fetch_rsp : lsu_rsp;
                if (src == SRC_FETCH) begin
                    name = "o_fetch_rsp.data";
                end else begin
                    name = "o_lsu_rsp.data";
                end
                check_src(want.src, src);
                if (want.is_read) begin
                    check_data(want.rsp, got, name);
                end
                done_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            report_failure($sformatf("Timeout: run still busy after %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        biu_req_t req;
        biu_req_t other;
        int       n;
        fetch_req = '0;
        lsu_req   = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // Preload the window so every later read has known data
        for (int a = 0; a < TEST_BYTES; a += BIU_DATA_SIZE) begin
            req      = random_req(WRITE);
            req.len  = LEN_16B;
            req.sel  = '1;
            req.addr = WB_ADDR_WIDTH'(a);
            for (int i = 0; i < BIU_DATA_SIZE; i++) begin
                req.data[i*8 +: 8] = fill_byte(WB_ADDR_WIDTH'(a + i));
            end
            run_op(SRC_LSU, req);
        end

        // Full-select write and read back for each length
        for (int l = 0; l < 5; l++) begin
            req     = random_req(WRITE);
            req.len = biu_len_t'(3'(l));
            req.sel = '1;
            run_op(SRC_LSU, req);
            req.func = READ;
            run_op(SRC_LSU, req);
        end

        // Partial byte selects, read 16 bytes to see untouched ones
        repeat (PATCH_OPS) begin
            req = random_req(WRITE);
            run_op(SRC_FETCH, req);
            req.func = READ;
            req.len  = LEN_16B;
            run_op(SRC_FETCH, req);
        end

        repeat (MERGE_OPS) begin
            req = random_req(RMW);
            run_op(SRC_LSU, req);
            req.func = READ;
            req.len  = LEN_16B;
            run_op(SRC_LSU, req);
        end

        // Short lengths: one beat, upper words zero
        repeat (SHORT_OPS) begin
            req     = random_req(WRITE);
            req.len = req.addr[2] ? LEN_2B : LEN_1B;
            run_op(SRC_FETCH, req);
            req.func = READ;
            run_op(SRC_LSU, req);
        end

        repeat (PAIR_OPS) begin
            req   = random_req(READ);
            other = random_req(READ);
            run_pair(req, other);
        end

        n = 0;
        while (n < MIX_OPS) begin
            req = random_req(random_func());
            if (req.addr[3] && n + 2 <= MIX_OPS) begin
                other = random_req(random_func());
                run_pair(req, other);
                n += 2;
            end else begin
                run_op(req.addr[4] ? SRC_FETCH : SRC_LSU, req);
                n += 1;
            end
        end

        repeat (2) @(posedge clk);
        if (pending_q.size() == 0 && done_count == TOTAL_OPS) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            report_failure($sformatf("Only %0d of %0d responses arrived",
                                     done_count, TOTAL_OPS));
        end
    end

endmodule

/* hdl/biu_top.sv */
//****************************************
// BIU top: arbiter, Wishbone controller
// and on-chip SRAM slave
//****************************************
`timescale 1ns/1ns

module biu_top (
    input  logic              i_wb_clk,
    input  logic              i_rst,
    input  biu_pkg::biu_req_t i_fetch_req,
    input  biu_pkg::biu_req_t i_lsu_req,
    output biu_pkg::biu_rsp_t o_fetch_rsp,
    output biu_pkg::biu_rsp_t o_lsu_rsp
);

    import biu_pkg::*;

    biu_req_t arb_req;
    biu_rsp_t ctl_rsp;
    wb_m2s_t  wb_m2s;
    wb_s2m_t  wb_s2m;

    biu_arbiter u_arbiter (
        .i_wb_clk    (i_wb_clk),
        .i_rst       (i_rst),
        .i_fetch_req (i_fetch_req),
        .i_lsu_req   (i_lsu_req),
        .o_fetch_rsp (o_fetch_rsp),
        .o_lsu_rsp   (o_lsu_rsp),
        .o_req       (arb_req),
        .i_rsp       (ctl_rsp)
    );

    biu_controller_wb u_controller (
        .i_wb_clk (i_wb_clk),
        .i_rst    (i_rst),
        .i_req    (arb_req),
        .o_rsp    (ctl_rsp),
        .o_wb     (wb_m2s),
        .i_wb     (wb_s2m)
    );

    // Bus ends here in the local SRAM
    wb_sram u_sram (
        .i_wb_clk (i_wb_clk),
        .i_rst    (i_rst),
        .i_wb     (wb_m2s),
        .o_wb     (wb_s2m)
    );

endmodule

/* hdl/wb_sram.sv */
//****************************************
// Wishbone slave word memory with byte
// selects and registered acknowledge
//****************************************
`timescale 1ns/1ns

module wb_sram (
    input  logic             i_wb_clk,
    input  logic             i_rst,
    input  biu_pkg::wb_m2s_t i_wb,
    output biu_pkg::wb_s2m_t o_wb
);

    import biu_pkg::*;

    logic [WB_DATA_WIDTH-1:0]  mem [SRAM_DEPTH];
    logic [SRAM_IDX_WIDTH-1:0] word_idx;
    logic                      ack_r;
    logic [WB_DATA_WIDTH-1:0]  rdata_r;
    logic                      req_hit;

    // Word index sits above the byte offset
    assign word_idx = i_wb.addr[WB_OFFSET_WIDTH +: SRAM_IDX_WIDTH];

    // A new beat is one that has not been acknowledged yet
    assign req_hit = i_wb.cyc && i_wb.stb && !ack_r;

    always_ff @(posedge i_wb_clk) begin
        if (i_rst) begin
            ack_r <= 1'b0;
        end else begin
            ack_r <= req_hit;
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (req_hit && i_wb.we) begin
            for (int i = 0; i < WB_DATA_SIZE; i++) begin
                if (i_wb.sel[i]) begin
                    mem[word_idx][i*8 +: 8] <= i_wb.data[i*8 +: 8];
                end
            end
        end
        if (req_hit && !i_wb.we) begin
            rdata_r <= mem[word_idx];
        end
    end

    assign o_wb.ack  = ack_r;
    assign o_wb.data = rdata_r;

    a_ack_in_cycle: assert property (@(posedge i_wb_clk) disable iff (i_rst)
        o_wb.ack |-> (i_wb.cyc && i_wb.stb));

endmodule

/* hdl/biu_controller_wb.sv */
//****************************************
// Wishbone master FSM that turns one BIU
// request into burst or RMW bus beats
//****************************************
`timescale 1ns/1ns

module biu_controller_wb (
    input  logic              i_wb_clk,
    input  logic              i_rst,
    input  biu_pkg::biu_req_t i_req,
    output biu_pkg::biu_rsp_t o_rsp,
    output biu_pkg::wb_m2s_t  o_wb,
    input  biu_pkg::wb_s2m_t  i_wb
);

    import biu_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_SEND       = 3'd1,
        ST_RMW_READ   = 3'd2,
        ST_RMW_MODIFY = 3'd3,
        ST_RMW_WRITE  = 3'd4,
        ST_DONE       = 3'd5
    } ctl_state_t;

    ctl_state_t                state_r;
    ctl_state_t                state_next;
    logic [BIU_CNT_WIDTH-1:0]  cnt_r;
    logic [BIU_CNT_WIDTH-1:0]  cnt_next;
    logic [BIU_IDX_WIDTH-1:0]  idx_r;
    logic [BIU_IDX_WIDTH-1:0]  idx_next;
    logic                      done_r;
    logic                      done_next;
    logic [BIU_DATA_WIDTH-1:0] data_r;
    logic [BIU_DATA_WIDTH-1:0] data_next;
    wb_m2s_t                   wb_r;
    wb_m2s_t                   wb_next;
    logic [WB_DATA_WIDTH-1:0]  rmw_word;

    // Merge selected request bytes over the word read back in the RMW read
    always_comb begin
        logic [WB_DATA_SIZE-1:0]  req_sel;
        logic [WB_DATA_WIDTH-1:0] old_word;
        logic [WB_DATA_WIDTH-1:0] new_word;

        req_sel  = i_req.sel[idx_r*WB_DATA_SIZE +: WB_DATA_SIZE];
        old_word = data_r[idx_r*WB_DATA_WIDTH +: WB_DATA_WIDTH];
        new_word = i_req.data[idx_r*WB_DATA_WIDTH +: WB_DATA_WIDTH];
        for (int i = 0; i < WB_DATA_SIZE; i++) begin
            rmw_word[i*8 +: 8] = req_sel[i] ? new_word[i*8 +: 8] : old_word[i*8 +: 8];
        end
    end

    always_comb begin
        logic [BIU_IDX_WIDTH-1:0] idx_inc;
        logic                     last_beat;

        idx_inc   = idx_r + 1'b1;
        last_beat = (cnt_r == BIU_CNT_WIDTH'(1));

        state_next = state_r;
        cnt_next   = cnt_r;
        idx_next   = idx_r;
        done_next  = 1'b0;
        data_next  = data_r;
        wb_next    = wb_r;

        unique case (state_r)
            ST_IDLE: begin
                cnt_next    = biu_beats(i_req.len);
                idx_next    = '0;
                data_next   = '0;
                wb_next.cyc = i_req.en;
                wb_next.stb = i_req.en;
                wb_next.bte = LINEAR;
                wb_next.addr = i_req.addr;
                if (i_req.en && i_req.func == RMW) begin
                    // Each RMW beat reads the whole word first
                    state_next  = ST_RMW_READ;
                    wb_next.we  = 1'b0;
                    wb_next.cti = CLASSIC;
                    wb_next.sel = '1;
                end else if (i_req.en) begin
                    state_next   = ST_SEND;
                    wb_next.we   = (i_req.func == WRITE);
                    wb_next.cti  = (cnt_next == BIU_CNT_WIDTH'(1)) ? END_OF_BURST : INCREMENTING;
                    wb_next.sel  = i_req.sel[WB_DATA_SIZE-1:0];
                    wb_next.data = i_req.data[WB_DATA_WIDTH-1:0];
                end
            end
            ST_SEND: begin
                if (i_wb.ack) begin
                    if (!wb_r.we) begin
                        data_next[idx_r*WB_DATA_WIDTH +: WB_DATA_WIDTH] = i_wb.data;
                    end
                    cnt_next     = cnt_r - 1'b1;
                    idx_next     = idx_inc;
                    wb_next.addr = wb_r.addr + WB_ADDR_WIDTH'(WB_DATA_SIZE);
                    if (last_beat) begin
                        state_next  = ST_DONE;
                        done_next   = 1'b1;
                        wb_next.cyc = 1'b0;
                        wb_next.stb = 1'b0;
                        wb_next.we  = 1'b0;
                    end else begin
                        wb_next.sel  = i_req.sel[idx_inc*WB_DATA_SIZE +: WB_DATA_SIZE];
                        wb_next.data = i_req.data[idx_inc*WB_DATA_WIDTH +: WB_DATA_WIDTH];
                        wb_next.cti  = (cnt_r == BIU_CNT_WIDTH'(2)) ? END_OF_BURST : INCREMENTING;
                    end
                end
            end
            ST_RMW_READ: begin
                if (i_wb.ack) begin
                    state_next  = ST_RMW_MODIFY;
                    data_next[idx_r*WB_DATA_WIDTH +: WB_DATA_WIDTH] = i_wb.data;
                    wb_next.stb = 1'b0;
                end
            end
            ST_RMW_MODIFY: begin
                // cyc stays high so the read and write form one locked cycle
                state_next   = ST_RMW_WRITE;
                wb_next.stb  = 1'b1;
                wb_next.we   = 1'b1;
                wb_next.data = rmw_word;
            end
            ST_RMW_WRITE: begin
                if (i_wb.ack) begin
                    cnt_next     = cnt_r - 1'b1;
                    idx_next     = idx_inc;
                    wb_next.addr = wb_r.addr + WB_ADDR_WIDTH'(WB_DATA_SIZE);
                    wb_next.we   = 1'b0;
                    if (last_beat) begin
                        state_next  = ST_DONE;
                        done_next   = 1'b1;
                        wb_next.cyc = 1'b0;
                        wb_next.stb = 1'b0;
                    end else begin
                        state_next = ST_RMW_READ;
                    end
                end
            end
            ST_DONE: begin
                state_next  = ST_IDLE;
                wb_next.cyc = 1'b0;
                wb_next.stb = 1'b0;
                wb_next.we  = 1'b0;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_wb_clk) begin
        state_r <= state_next;
        cnt_r   <= cnt_next;
        idx_r   <= idx_next;
        done_r  <= done_next;
        data_r  <= data_next;
        wb_r    <= wb_next;
        if (i_rst) begin
            state_r <= ST_IDLE;
            done_r  <= 1'b0;
            wb_r.cyc <= 1'b0;
            wb_r.stb <= 1'b0;
            wb_r.we  <= 1'b0;
        end
    end

    assign o_wb      = wb_r;
    assign o_rsp.done = done_r;
    assign o_rsp.data = data_r;

    a_stb_in_cyc: assert property (@(posedge i_wb_clk) disable iff (i_rst)
        o_wb.stb |-> o_wb.cyc);

    a_done_pulse: assert property (@(posedge i_wb_clk) disable iff (i_rst)
        o_rsp.done |=> !o_rsp.done);

endmodule

/* hdl/biu_arbiter.sv */
//****************************************
// Fixed-priority arbiter between fetch and
// load/store requests that holds its grant
// until done
//****************************************
`timescale 1ns/1ns

module biu_arbiter (
    input  logic              i_wb_clk,
    input  logic              i_rst,
    input  biu_pkg::biu_req_t i_fetch_req,
    input  biu_pkg::biu_req_t i_lsu_req,
    output biu_pkg::biu_rsp_t o_fetch_rsp,
    output biu_pkg::biu_rsp_t o_lsu_rsp,
    output biu_pkg::biu_req_t o_req,
    input  biu_pkg::biu_rsp_t i_rsp
);

    import biu_pkg::*;

    logic     busy_r;
    biu_src_t grant_r;
    biu_req_t granted_req;
    logic     fetch_own;
    logic     lsu_own;

    // Fetch wins whenever both requesters ask at once
    always_ff @(posedge i_wb_clk) begin
        if (i_rst) begin
            busy_r  <= 1'b0;
            grant_r <= SRC_FETCH;
        end else if (!busy_r) begin
            if (i_fetch_req.en) begin
                busy_r  <= 1'b1;
                grant_r <= SRC_FETCH;
            end else if (i_lsu_req.en) begin
                busy_r  <= 1'b1;
                grant_r <= SRC_LSU;
            end
        end else if (i_rsp.done) begin
            busy_r <= 1'b0;
        end
    end

    assign granted_req = (grant_r == SRC_FETCH) ? i_fetch_req : i_lsu_req;
    assign fetch_own   = busy_r && (grant_r == SRC_FETCH);
    assign lsu_own     = busy_r && (grant_r == SRC_LSU);

    // en is masked on the done cycle so the controller cannot restart
    always_comb begin
        o_req    = granted_req;
        o_req.en = busy_r && granted_req.en && !i_rsp.done;
    end

    always_comb begin
        o_fetch_rsp.done = fetch_own && i_rsp.done;
        o_fetch_rsp.data = fetch_own ? i_rsp.data : '0;
        o_lsu_rsp.done   = lsu_own && i_rsp.done;
        o_lsu_rsp.data   = lsu_own ? i_rsp.data : '0;
    end

    // Granted request seen by the controller stays steady until done
    a_grant_held: assert property (@(posedge i_wb_clk) disable iff (i_rst)
        (busy_r && !i_rsp.done) |=> (i_rsp.done || $stable(o_req)));

endmodule

/* hdl/biu_pkg.sv */
//****************************************
// Bus interface unit package: widths,
// request and Wishbone enums, bus structs
//****************************************

package biu_pkg;

    // Payload and bus widths
    localparam int BIU_DATA_SIZE   = 16;
    localparam int BIU_DATA_WIDTH  = BIU_DATA_SIZE * 8;
    localparam int WB_DATA_WIDTH   = 32;
    localparam int WB_DATA_SIZE    = WB_DATA_WIDTH / 8;
    localparam int WB_ADDR_WIDTH   = 12;
    localparam int SRAM_DEPTH      = 1024;

    // Derived sizes for beat counting and word indexing
    localparam int BIU_BEAT_MAX    = BIU_DATA_SIZE / WB_DATA_SIZE;
    localparam int BIU_CNT_WIDTH   = $clog2(BIU_BEAT_MAX + 1);
    localparam int BIU_IDX_WIDTH   = $clog2(BIU_BEAT_MAX);
    localparam int WB_OFFSET_WIDTH = $clog2(WB_DATA_SIZE);
    localparam int SRAM_IDX_WIDTH  = $clog2(SRAM_DEPTH);

    typedef enum logic [1:0] {
        READ  = 2'd0,
        WRITE = 2'd1,
        RMW   = 2'd2
    } biu_func_t;

    typedef enum logic [2:0] {
        LEN_1B  = 3'd0,
        LEN_2B  = 3'd1,
        LEN_4B  = 3'd2,
        LEN_8B  = 3'd3,
        LEN_16B = 3'd4
    } biu_len_t;

    typedef enum logic {
        SRC_FETCH = 1'b0,
        SRC_LSU   = 1'b1
    } biu_src_t;

    // Wishbone B4 cycle type and burst type encodings
    typedef enum logic [2:0] {
        CLASSIC      = 3'b000,
        INCREMENTING = 3'b010,
        END_OF_BURST = 3'b111
    } wb_cti_t;

    typedef enum logic [1:0] {
        LINEAR = 2'b00
    } wb_bte_t;

    typedef struct packed {
        logic                      en;
        biu_func_t                 func;
        biu_len_t                  len;
        logic [BIU_DATA_SIZE-1:0]  sel;
        logic [WB_ADDR_WIDTH-1:0]  addr;
        logic [BIU_DATA_WIDTH-1:0] data;
    } biu_req_t;

    typedef struct packed {
        logic                      done;
        logic [BIU_DATA_WIDTH-1:0] data;
    } biu_rsp_t;

    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        wb_cti_t                  cti;
        wb_bte_t                  bte;
        logic [WB_DATA_SIZE-1:0]  sel;
        logic [WB_ADDR_WIDTH-1:0] addr;
        logic [WB_DATA_WIDTH-1:0] data;
    } wb_m2s_t;

    typedef struct packed {
        logic                     ack;
        logic [WB_DATA_WIDTH-1:0] data;
    } wb_s2m_t;

    // Beats per request, never less than one word
    function automatic logic [BIU_CNT_WIDTH-1:0] biu_beats(input biu_len_t len);
        case (len)
            LEN_8B:  biu_beats = BIU_CNT_WIDTH'(8 / WB_DATA_SIZE);
            LEN_16B: biu_beats = BIU_CNT_WIDTH'(16 / WB_DATA_SIZE);
            default: biu_beats = BIU_CNT_WIDTH'(1);
        endcase
    endfunction

endpackage
